// File: hdl/dma_endpoint_pkg.sv
// Shared definitions of the register access endpoint:
// data path and bus widths, the register address map,
// the access source encoding and the command, response
// and DMA write beat structures passed between stages.

package dma_endpoint_pkg;

    // Core register and bus widths
    localparam int DATAPATH_WIDTH = 20;
    localparam int BUS_WIDTH = 32;
    localparam int REG_ADDR_WIDTH = 8;

    // Address 0 holds the channel count, data registers follow it
    localparam int NUM_REGS = 256;
    localparam int CHANNEL_WIDTH = 3;
    localparam logic [REG_ADDR_WIDTH-1:0] CHANNEL_ADDR = '0;

    // Requester of an access, carried along so the response finds its way back
    typedef enum logic {
        src_bus = 1'b0,
        src_stream = 1'b1
    } source_t;

    // One register command moving through the pipeline
    typedef struct packed {
        logic valid;
        logic write;
        source_t source;
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [BUS_WIDTH-1:0] data;
    } reg_cmd_t;

    // One read result on its way back to the requester
    typedef struct packed {
        logic valid;
        source_t source;
        logic [BUS_WIDTH-1:0] data;
    } reg_rsp_t;

    // Payload of a DMA write beat
    typedef struct packed {
        logic [REG_ADDR_WIDTH-1:0] dest;
        logic [DATAPATH_WIDTH-1:0] data;
    } stream_write_t;

endpackage

// File: hdl/apb_register_port.sv
// APB slave stage of the register endpoint.
// Turns each APB transfer into one register command and
// stretches the access phase until the command completes.

`timescale 1ns/10ps

module apb_register_port (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    output dma_endpoint_pkg::reg_cmd_t bus_cmd,
    input logic bus_cmd_ready,
    input dma_endpoint_pkg::reg_rsp_t bus_rsp
);
    import dma_endpoint_pkg::*;

    typedef enum logic [1:0] {
        idle,
        request,
        wait_response,
        done
    } state_t;

    state_t state;
    logic write_q;
    logic [REG_ADDR_WIDTH-1:0] addr_q;
    logic [BUS_WIDTH-1:0] data_q;

    always_ff @(posedge clock) begin
        if (!reset) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    // Start only on a setup phase, never on a stale access phase
                    if (psel && !penable) begin
                        write_q <= pwrite;
                        addr_q <= paddr[REG_ADDR_WIDTH+1:2];
                        data_q <= pwdata;
                        state <= request;
                    end
                end
                request: begin
                    if (bus_cmd_ready) begin
                        state <= write_q ? done : wait_response;
                    end
                end
                wait_response: begin
                    if (bus_rsp.valid) begin
                        prdata <= bus_rsp.data;
                        state <= done;
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_comb begin
        bus_cmd.valid = (state == request);
        bus_cmd.write = write_q;
        bus_cmd.source = src_bus;
        bus_cmd.addr = addr_q;
        bus_cmd.data = data_q;
    end

    // The transfer completes in the single cycle spent in done
    assign pready = (state == done);
    assign pslverr = 1'b0;

endmodule

// File: hdl/access_arbiter.sv
// Command stage of the register endpoint.
// Fixed priority grant between DMA writes, DMA read requests
// and bus commands, the channel count register and the
// filtering of accesses to address 0.

`timescale 1ns/10ps

module access_arbiter (
    input logic clock,
    input logic reset,
    input logic dma_write_valid,
    output logic dma_write_ready,
    input dma_endpoint_pkg::stream_write_t dma_write,
    input logic read_req_valid,
    output logic read_req_ready,
    input logic [dma_endpoint_pkg::REG_ADDR_WIDTH-1:0] read_req_addr,
    input dma_endpoint_pkg::reg_cmd_t bus_cmd,
    output logic bus_cmd_ready,
    input logic stall,
    output dma_endpoint_pkg::reg_cmd_t arb_cmd,
    output dma_endpoint_pkg::reg_rsp_t chan_rsp,
    output logic [dma_endpoint_pkg::CHANNEL_WIDTH-1:0] n_channels
);
    import dma_endpoint_pkg::*;

    logic ready_en;
    logic write_take;
    logic read_take;
    logic bus_take;
    reg_cmd_t next_cmd;

    // A lower priority requester is only ready when nobody above it asks
    assign dma_write_ready = ready_en && !stall;
    assign read_req_ready = ready_en && !stall && !dma_write_valid;
    assign bus_cmd_ready = ready_en && !stall && !dma_write_valid && !read_req_valid;

    assign write_take = dma_write_valid && dma_write_ready;
    assign read_take = read_req_valid && read_req_ready;
    assign bus_take = bus_cmd.valid && bus_cmd_ready;

    always_comb begin
        next_cmd = '0;
        if (write_take) begin
            // Stream writes to the channel count are swallowed here
            if (dma_write.dest != CHANNEL_ADDR) begin
                next_cmd.valid = 1'b1;
                next_cmd.write = 1'b1;
                next_cmd.source = src_stream;
                next_cmd.addr = dma_write.dest;
                next_cmd.data = BUS_WIDTH'(dma_write.data);
            end
        end else if (read_take) begin
            if (read_req_addr != CHANNEL_ADDR) begin
                next_cmd.valid = 1'b1;
                next_cmd.source = src_stream;
                next_cmd.addr = read_req_addr;
            end
        end else if (bus_take) begin
            if (bus_cmd.addr != CHANNEL_ADDR) begin
                next_cmd = bus_cmd;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            ready_en <= 1'b0;
            arb_cmd <= '0;
            chan_rsp <= '0;
            n_channels <= '0;
        end else begin
            ready_en <= 1'b1;
            // A stalled command waits here until the response stream drains
            if (!stall) begin
                arb_cmd <= next_cmd;
            end
            chan_rsp.valid <= 1'b0;
            if (bus_take && bus_cmd.addr == CHANNEL_ADDR) begin
                if (bus_cmd.write) begin
                    n_channels <= bus_cmd.data[CHANNEL_WIDTH-1:0];
                end else begin
                    chan_rsp.valid <= 1'b1;
                    chan_rsp.source <= src_bus;
                    chan_rsp.data <= BUS_WIDTH'(n_channels);
                end
            end
        end
    end

endmodule

// File: hdl/register_file.sv
// Access stage of the register endpoint.
// Holds the core data registers and performs one registered
// read or write per cycle, freezing its result while the
// response stream is back-pressured.

`timescale 1ns/10ps

module register_file (
    input logic clock,
    input logic reset,
    input dma_endpoint_pkg::reg_cmd_t arb_cmd,
    input logic stall,
    output dma_endpoint_pkg::reg_rsp_t file_rsp
);
    import dma_endpoint_pkg::*;

    // Address 0 is the channel count and has no storage here
    logic [DATAPATH_WIDTH-1:0] regs [1:NUM_REGS-1];

    always_ff @(posedge clock) begin
        if (!reset) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (!stall) begin
            if (arb_cmd.valid && arb_cmd.write) begin
                // Only the low bits fit a core register
                regs[arb_cmd.addr] <= arb_cmd.data[DATAPATH_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge clock) begin
        if (!reset) begin
            file_rsp.valid <= 1'b0;
        end else if (!stall) begin
            file_rsp.valid <= arb_cmd.valid && !arb_cmd.write;
            file_rsp.source <= arb_cmd.source;
            file_rsp.data <= BUS_WIDTH'(regs[arb_cmd.addr]);
        end
    end

endmodule

// File: hdl/response_router.sv
// Response stage of the register endpoint.
// Merges channel count and register file results and routes
// each one either to the APB port or to the DMA read
// response stream, raising stall when the stream refuses it.

`timescale 1ns/10ps

module response_router (
    input dma_endpoint_pkg::reg_rsp_t chan_rsp,
    input dma_endpoint_pkg::reg_rsp_t file_rsp,
    output dma_endpoint_pkg::reg_rsp_t bus_rsp,
    output logic read_rsp_valid,
    input logic read_rsp_ready,
    output logic [dma_endpoint_pkg::DATAPATH_WIDTH-1:0] read_rsp_data,
    output logic stall
);
    import dma_endpoint_pkg::*;

    reg_rsp_t stream_rsp;

    // Two valid inputs in the same cycle always carry different sources,
    // so each destination sees at most one of them
    always_comb begin
        bus_rsp = '0;
        if (file_rsp.valid && file_rsp.source == src_bus) begin
            bus_rsp = file_rsp;
        end else if (chan_rsp.valid && chan_rsp.source == src_bus) begin
            bus_rsp = chan_rsp;
        end
    end

    always_comb begin
        stream_rsp = '0;
        if (file_rsp.valid && file_rsp.source == src_stream) begin
            stream_rsp = file_rsp;
        end else if (chan_rsp.valid && chan_rsp.source == src_stream) begin
            stream_rsp = chan_rsp;
        end
    end

    assign read_rsp_valid = stream_rsp.valid;
    assign read_rsp_data = stream_rsp.data[DATAPATH_WIDTH-1:0];

    // A refused stream beat freezes everything behind it
    assign stall = read_rsp_valid && !read_rsp_ready;

endmodule

// File: hdl/dma_endpoint_top.sv
// Top level of the register access endpoint.
// Chains the APB port, the arbiter, the register file and
// the response router, and brings out the bus, the three
// DMA streams and the channel count.

`timescale 1ns/10ps

module dma_endpoint_top (
    input logic clock,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pwrite,
    input logic [31:0] paddr,
    input logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic pready,
    output logic pslverr,
    input logic dma_write_valid,
    output logic dma_write_ready,
    input dma_endpoint_pkg::stream_write_t dma_write,
    input logic read_req_valid,
    output logic read_req_ready,
    input logic [dma_endpoint_pkg::REG_ADDR_WIDTH-1:0] read_req_addr,
    output logic read_rsp_valid,
    input logic read_rsp_ready,
    output logic [dma_endpoint_pkg::DATAPATH_WIDTH-1:0] read_rsp_data,
    output logic [dma_endpoint_pkg::CHANNEL_WIDTH-1:0] n_channels
);
    import dma_endpoint_pkg::*;

    reg_cmd_t bus_cmd;
    logic bus_cmd_ready;
    reg_rsp_t bus_rsp;
    reg_cmd_t arb_cmd;
    reg_rsp_t chan_rsp;
    reg_rsp_t file_rsp;
    logic stall;

    apb_register_port bus_port (
        .clock(clock),
        .reset(reset),
        .psel(psel),
        .penable(penable),
        .pwrite(pwrite),
        .paddr(paddr),
        .pwdata(pwdata),
        .prdata(prdata),
        .pready(pready),
        .pslverr(pslverr),
        .bus_cmd(bus_cmd),
        .bus_cmd_ready(bus_cmd_ready),
        .bus_rsp(bus_rsp)
    );

    access_arbiter arbiter (
        .clock(clock),
        .reset(reset),
        .dma_write_valid(dma_write_valid),
        .dma_write_ready(dma_write_ready),
        .dma_write(dma_write),
        .read_req_valid(read_req_valid),
        .read_req_ready(read_req_ready),
        .read_req_addr(read_req_addr),
        .bus_cmd(bus_cmd),
        .bus_cmd_ready(bus_cmd_ready),
        .stall(stall),
        .arb_cmd(arb_cmd),
        .chan_rsp(chan_rsp),
        .n_channels(n_channels)
    );

    register_file registers (
        .clock(clock),
        .reset(reset),
        .arb_cmd(arb_cmd),
        .stall(stall),
        .file_rsp(file_rsp)
    );

    response_router router (
        .chan_rsp(chan_rsp),
        .file_rsp(file_rsp),
        .bus_rsp(bus_rsp),
        .read_rsp_valid(read_rsp_valid),
        .read_rsp_ready(read_rsp_ready),
        .read_rsp_data(read_rsp_data),
        .stall(stall)
    );

endmodule

// File: verif/dma_endpoint_tb.sv
// Directed testbench of the register access endpoint:
// clock, reset and watchdog, APB and DMA stream drivers,
// compare tasks, a register model and six directed tests.

`timescale 1ns/10ps

module dma_endpoint_tb;
    import dma_endpoint_pkg::*;

    localparam int CLOCK_PERIOD = 8;
    localparam int SETTLE = 1;
    localparam int NUM_TESTS = 6;
    localparam int TEST_BUDGET_NS = 2000;

    logic clock;
    logic reset;
    logic psel;
    logic penable;
    logic pwrite;
    logic [31:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic pready;
    logic pslverr;
    logic dma_write_valid;
    logic dma_write_ready;
    stream_write_t dma_write;
    logic read_req_valid;
    logic read_req_ready;
    logic [REG_ADDR_WIDTH-1:0] read_req_addr;
    logic read_rsp_valid;
    logic read_rsp_ready;
    logic [DATAPATH_WIDTH-1:0] read_rsp_data;
    logic [CHANNEL_WIDTH-1:0] n_channels;

    // Expected register contents and channel count
    logic [DATAPATH_WIDTH-1:0] model [NUM_REGS];
    bit written [NUM_REGS];
    logic [CHANNEL_WIDTH-1:0] chan_model;
    int errors = 0;
    int cycle = 0;
    logic [REG_ADDR_WIDTH-1:0] wr_addr_q [$];
    logic [DATAPATH_WIDTH-1:0] wr_data_q [$];
    logic [REG_ADDR_WIDTH-1:0] rd_addr_q [$];
    logic [DATAPATH_WIDTH-1:0] expected_q [$];
    int accept_cycle [$];

    dma_endpoint_top DUT (.*);

    initial begin
        clock = 1'b0;
        forever #(CLOCK_PERIOD / 2) clock = ~clock;
    end

    always @(posedge clock) cycle <= cycle + 1;

    initial begin
        #(NUM_TESTS * TEST_BUDGET_NS);
        $display("Timeout: the tests did not finish within %0d ns", NUM_TESTS * TEST_BUDGET_NS);
        $display("CHECKS FAILED");
        $fatal(1, "Simulation stopped by the watchdog");
    end

    task automatic stop_on_error();
        errors++;
        $display("CHECKS FAILED");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic abort_run(input string reason);
        $display("Error at %0t ns: %s", $time, reason);
        stop_on_error();
    endtask

    task automatic check_bus_word(input logic [BUS_WIDTH-1:0] got,
                                  input logic [BUS_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s returned %h, expected %h",
                     $time, what, got, expected);
            stop_on_error();
        end
    endtask

    task automatic check_stream_data(input logic [DATAPATH_WIDTH-1:0] got,
                                     input logic [DATAPATH_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s returned %h, expected %h",
                     $time, what, got, expected);
            stop_on_error();
        end
    endtask

    task automatic check_channels(input logic [CHANNEL_WIDTH-1:0] got,
                                  input logic [CHANNEL_WIDTH-1:0] expected, input string what);
        if (got !== expected) begin
            $display("CHECK FAILED at %0t ns: %s is %0d, expected %0d",
                     $time, what, got, expected);
            stop_on_error();
        end
    endtask

    function automatic logic [REG_ADDR_WIDTH-1:0] random_reg_addr();
        return REG_ADDR_WIDTH'($urandom_range(1, NUM_REGS - 1));
    endfunction

    function automatic logic [REG_ADDR_WIDTH-1:0] next_reg_addr(
            input logic [REG_ADDR_WIDTH-1:0] addr);
        if (addr == REG_ADDR_WIDTH'(NUM_REGS - 1)) begin
            return REG_ADDR_WIDTH'(1);
        end
        return addr + REG_ADDR_WIDTH'(1);
    endfunction

    task automatic apb_transfer(input logic write, input logic [REG_ADDR_WIDTH-1:0] addr,
                                input logic [BUS_WIDTH-1:0] wdata,
                                output logic [BUS_WIDTH-1:0] rdata);
        @(negedge clock);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = 32'(addr) << 2;
        pwdata = wdata;
        @(negedge clock);
        penable = 1'b1;
        // The access phase lasts until the slave raises pready
        while (!pready) begin
            @(negedge clock);
        end
        if (pslverr) begin
            abort_run("APB slave signalled an error response");
        end
        rdata = prdata;
        @(negedge clock);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [REG_ADDR_WIDTH-1:0] addr,
                             input logic [BUS_WIDTH-1:0] data);
        logic [BUS_WIDTH-1:0] ignored;
        apb_transfer(1'b1, addr, data, ignored);
        if (addr == CHANNEL_ADDR) begin
            chan_model = data[CHANNEL_WIDTH-1:0];
        end else begin
            model[addr] = data[DATAPATH_WIDTH-1:0];
            written[addr] = 1'b1;
        end
    endtask

    task automatic apb_read(input logic [REG_ADDR_WIDTH-1:0] addr,
                            output logic [BUS_WIDTH-1:0] data);
        apb_transfer(1'b0, addr, '0, data);
    endtask

    // Sends every queued beat, back to back while the DUT stays ready
    task automatic stream_write();
        int i;
        for (i = 0; i < wr_addr_q.size(); i++) begin
            @(negedge clock);
            dma_write_valid = 1'b1;
            dma_write.dest = wr_addr_q[i];
            dma_write.data = wr_data_q[i];
            #SETTLE;
            while (!dma_write_ready) begin
                @(negedge clock);
                #SETTLE;
            end
            @(posedge clock);
            if (wr_addr_q[i] != CHANNEL_ADDR) begin
                model[wr_addr_q[i]] = wr_data_q[i];
                written[wr_addr_q[i]] = 1'b1;
            end
        end
        @(negedge clock);
        dma_write_valid = 1'b0;
        wr_addr_q.delete();
        wr_data_q.delete();
    endtask

    task automatic send_read_requests();
        int i;
        for (i = 0; i < rd_addr_q.size(); i++) begin
            @(negedge clock);
            read_req_valid = 1'b1;
            read_req_addr = rd_addr_q[i];
            #SETTLE;
            while (!read_req_ready) begin
                @(negedge clock);
                #SETTLE;
            end
            accept_cycle.push_back(cycle);
            @(posedge clock);
        end
        @(negedge clock);
        read_req_valid = 1'b0;
    endtask

    task automatic collect_read_responses(input bit throttle);
        int received;
        int span_left;
        logic hold_ready;
        received = 0;
        span_left = 0;
        hold_ready = 1'b0;
        while (received < expected_q.size()) begin
            @(negedge clock);
            // Ready toggles in spans of random length when throttled
            if (throttle) begin
                if (span_left == 0) begin
                    hold_ready = !hold_ready;
                    span_left = $urandom_range(1, 5);
                end
                span_left--;
                read_rsp_ready = hold_ready;
            end else begin
                read_rsp_ready = 1'b1;
            end
            #SETTLE;
            if (read_rsp_valid && read_rsp_ready) begin
                check_stream_data(read_rsp_data, expected_q[received],
                                  $sformatf("read response %0d", received));
                received++;
            end
        end
        @(negedge clock);
        read_rsp_ready = 1'b1;
    endtask

    task automatic stream_read(input bit throttle);
        int i;
        expected_q.delete();
        accept_cycle.delete();
        // Address 0 requests are dropped and expect no response
        for (i = 0; i < rd_addr_q.size(); i++) begin
            if (rd_addr_q[i] != CHANNEL_ADDR) begin
                expected_q.push_back(model[rd_addr_q[i]]);
            end
        end
        fork
            send_read_requests();
            collect_read_responses(throttle);
        join
        repeat (4) begin
            @(negedge clock);
            #SETTLE;
            if (read_rsp_valid) begin
                abort_run("read response stream produced an extra response");
            end
        end
        rd_addr_q.delete();
    endtask

    task automatic apb_register_access();
        logic [REG_ADDR_WIDTH-1:0] addrs [$];
        logic [REG_ADDR_WIDTH-1:0] addr;
        logic [BUS_WIDTH-1:0] rd;
        int i;
        for (i = 0; i < 10; i++) begin
            addr = random_reg_addr();
            addrs.push_back(addr);
            apb_write(addr, $urandom);
        end
        for (i = 0; i < addrs.size(); i++) begin
            apb_read(addrs[i], rd);
            check_bus_word(rd, BUS_WIDTH'(model[addrs[i]]), $sformatf("register %0d", addrs[i]));
        end
        addr = random_reg_addr();
        for (i = 0; i < 2; i++) begin
            while (written[addr]) begin
                addr = next_reg_addr(addr);
            end
            apb_read(addr, rd);
            check_bus_word(rd, '0, $sformatf("unwritten register %0d", addr));
            addr = next_reg_addr(addr);
        end
    endtask

    task automatic channel_count_access();
        logic [BUS_WIDTH-1:0] rd;
        int i;
        check_channels(n_channels, chan_model, "channel count after reset");
        for (i = 0; i < 3; i++) begin
            apb_write(CHANNEL_ADDR, $urandom);
            check_channels(n_channels, chan_model, "channel count after APB write");
            apb_read(CHANNEL_ADDR, rd);
            check_bus_word(rd, BUS_WIDTH'(chan_model), "APB read of the channel count");
        end
    endtask

    task automatic stream_write_visibility();
        logic [REG_ADDR_WIDTH-1:0] addrs [$];
        logic [DATAPATH_WIDTH-1:0] zero_data;
        logic [BUS_WIDTH-1:0] rd;
        int i;
        for (i = 0; i < 6; i++) begin
            addrs.push_back(random_reg_addr());
            wr_addr_q.push_back(addrs[i]);
            wr_data_q.push_back(DATAPATH_WIDTH'($urandom));
        end
        stream_write();
        for (i = 0; i < addrs.size(); i++) begin
            apb_read(addrs[i], rd);
            check_bus_word(rd, BUS_WIDTH'(model[addrs[i]]),
                           $sformatf("streamed register %0d", addrs[i]));
        end
        // Low bits differ from the count so a leak into it would show
        zero_data = DATAPATH_WIDTH'($urandom);
        zero_data[CHANNEL_WIDTH-1:0] = ~chan_model;
        wr_addr_q.push_back(CHANNEL_ADDR);
        wr_data_q.push_back(zero_data);
        stream_write();
        check_channels(n_channels, chan_model, "channel count after stream write to address 0");
        for (i = 0; i < addrs.size(); i++) begin
            apb_read(addrs[i], rd);
            check_bus_word(rd, BUS_WIDTH'(model[addrs[i]]), $sformatf("register %0d", addrs[i]));
        end
        apb_read(CHANNEL_ADDR, rd);
        check_bus_word(rd, BUS_WIDTH'(chan_model), "APB read of the channel count");
    endtask

    task automatic stream_read_order();
        logic [REG_ADDR_WIDTH-1:0] addrs [3];
        int i;
        for (i = 0; i < 3; i++) begin
            addrs[i] = random_reg_addr();
            wr_addr_q.push_back(addrs[i]);
            wr_data_q.push_back(DATAPATH_WIDTH'($urandom));
        end
        stream_write();
        rd_addr_q = {addrs[0], addrs[1], CHANNEL_ADDR, addrs[2], addrs[0]};
        stream_read(1'b0);
        if (accept_cycle[1] != accept_cycle[0] + 1) begin
            abort_run("read request stream did not accept two requests in a row");
        end
    endtask

    task automatic response_backpressure();
        logic [REG_ADDR_WIDTH-1:0] addr;
        int i;
        for (i = 0; i < 12; i++) begin
            if (i == 4) begin
                rd_addr_q.push_back(CHANNEL_ADDR);
            end else begin
                addr = random_reg_addr();
                rd_addr_q.push_back(addr);
                wr_addr_q.push_back(addr);
                wr_data_q.push_back(DATAPATH_WIDTH'($urandom));
            end
        end
        // Fresh stored values let a lost, repeated or reordered beat show up
        stream_write();
        stream_read(1'b1);
    endtask

    task automatic apb_read_under_stream_load();
        logic [REG_ADDR_WIDTH-1:0] target;
        logic [BUS_WIDTH-1:0] rd;
        int i;
        target = random_reg_addr();
        for (i = 0; i < 8; i++) begin
            wr_addr_q.push_back((i % 3 == 0 || i == 7) ? target : random_reg_addr());
            wr_data_q.push_back(DATAPATH_WIDTH'($urandom));
        end
        fork
            stream_write();
            begin
                repeat (2) @(negedge clock);
                apb_read(target, rd);
            end
        join
        check_bus_word(rd, BUS_WIDTH'(model[target]), "APB read issued during stream writes");
    endtask

    initial begin
        int i;
        void'($urandom(32'h4889));
        reset = 1'b0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        dma_write_valid = 1'b0;
        dma_write = '0;
        read_req_valid = 1'b0;
        read_req_addr = '0;
        read_rsp_ready = 1'b1;
        chan_model = '0;
        for (i = 0; i < NUM_REGS; i++) begin
            model[i] = '0;
            written[i] = 1'b0;
        end
        repeat (10) @(negedge clock);
        reset = 1'b1;
        @(negedge clock);
        apb_register_access();
        channel_count_access();
        stream_write_visibility();
        stream_read_order();
        response_backpressure();
        apb_read_under_stream_load();
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
hdl/dma_endpoint_pkg.sv
hdl/apb_register_port.sv
hdl/access_arbiter.sv
hdl/register_file.sv
hdl/response_router.sv
hdl/dma_endpoint_top.sv
verif/dma_endpoint_tb.sv

// File: Makefile
# Verilator build and run of the register endpoint testbench

VERILATOR ?= verilator
VERILATOR_FLAGS ?= --binary --timing
TOP ?= dma_endpoint_tb
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
FAIL_TEXT ?= CHECKS FAILED
PASS_TEXT ?= ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR VERILATOR_FLAGS TOP FILELIST BUILD_DIR LOG"

test:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_TEXT)" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_TEXT)" $(LOG); then echo "Simulation ended early"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
